//--- bench/gtiaTb.sv
// ################################################
// Testbench with clock, reset, display-buffer model,
// directed tests and compare tasks
// ################################################

`include "gtia_config.svh"

module gtiaTb
  import gtiaPkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TimeoutCycles = 64;

  logic     Fphi0;
  logic     rst;
  anCodeT   an;
  colorT    colbk;
  colorT    colpf0;
  colorT    colpf1;
  colorT    colpf2;
  colorT    colpf3;
  scanModeT scanMode;
  xCoordT   width;
  yCoordT   height;
  logic     dlistEnd;
  logic     dBufAck = 1'b0;
  logic     anTake;
  logic     dBufReq;
  bufAddrT  dBufAddr;
  rgbT      dBufData;
  logic     hblank;
  logic     vblank;
  bufAddrT  addrLog[$];
  rgbT      dataLog[$];

  gtiaTop gtiaTop_inst (
    .Fphi0(Fphi0), .rst(rst), .an(an), .colbk(colbk), .colpf0(colpf0),
    .colpf1(colpf1), .colpf2(colpf2), .colpf3(colpf3), .scanMode(scanMode),
    .width(width), .height(height), .dlistEnd(dlistEnd), .dBufAck(dBufAck),
    .anTake(anTake), .dBufReq(dBufReq), .dBufAddr(dBufAddr), .dBufData(dBufData),
    .hblank(hblank), .vblank(vblank)
  );

  always #4 Fphi0 = ~Fphi0;

  task automatic failNow(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic checkRgb(input string name, input rgbT exp, input rgbT act);
    if (exp !== act)
      failNow($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic checkAddr(input string name, input bufAddrT exp, input bufAddrT act);
    if (exp !== act)
      failNow($sformatf("mismatch %s: expected %0d, actual %0d", name, exp, act));
  endtask

  task automatic checkFlag(input string name, input logic exp, input logic act);
    if (exp !== act)
      failNow($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
  endtask

  // Each channel of the hue's base colour scaled by (lum+1)/16
  function automatic rgbT rgbFromColour(input colorT c);
    rgbT base;
    rgbT res;
    int lumPlus;
    base = hueTable[c[7:4]];
    lumPlus = int'(c[3:0]) + 1;
    res.r = 8'((int'(base.r) * lumPlus) / 16);
    res.g = 8'((int'(base.g) * lumPlus) / 16);
    res.b = 8'((int'(base.b) * lumPlus) / 16);
    return res;
  endfunction

  // Display buffer model that acks after 0 to 3 cycles and logs every write
  always begin : bufferModel
    int delay;
    int waited;
    @(negedge Fphi0);
    if (!rst && dBufReq && !dBufAck) begin
      delay = int'($urandom % 4);
      repeat (delay) @(negedge Fphi0);
      @(posedge Fphi0);
      addrLog.push_back(dBufAddr);
      dataLog.push_back(dBufData);
      dBufAck <= 1'b1;
      waited = 0;
      do begin
        @(negedge Fphi0);
        waited++;
        if (waited > TimeoutCycles)
          failNow("display buffer timed out waiting for dBufReq to drop");
      end while (dBufReq);
      @(posedge Fphi0);
      dBufAck <= 1'b0;
    end
  end

  task automatic waitIdle(input string name);
    int waited;
    waited = 0;
    do begin
      @(negedge Fphi0);
      waited++;
      if (waited > TimeoutCycles)
        failNow($sformatf("timeout in %s waiting for the handshake to finish", name));
    end while (dBufReq || dBufAck);
  endtask

  // Hold a code until taken, then check the logged write and return the blank flags
  task automatic writePixel(input anCodeT code, input string name, input bufAddrT expAddr,
                            input rgbT expRgb, output logic hb, output logic vb);
    int waited;
    waited = 0;
    @(posedge Fphi0);
    an <= code;
    do begin
      @(negedge Fphi0);
      waited++;
      if (waited > TimeoutCycles)
        failNow($sformatf("timeout in %s waiting for anTake", name));
    end while (!anTake);
    @(posedge Fphi0);
    an <= noTransmission;
    @(negedge Fphi0);
    hb = hblank;
    vb = vblank;
    waited = 0;
    while (addrLog.size() == 0) begin
      @(negedge Fphi0);
      waited++;
      if (waited > TimeoutCycles)
        failNow($sformatf("timeout in %s waiting for a display-buffer write", name));
    end
    checkAddr(name, expAddr, addrLog.pop_front());
    checkRgb(name, expRgb, dataLog.pop_front());
  endtask

  task automatic pulseDlistEnd();
    @(posedge Fphi0);
    dlistEnd <= 1'b1;
    @(posedge Fphi0);
    dlistEnd <= 1'b0;
  endtask

  task automatic restartFrame(input scanModeT mode, input int w, input int h);
    waitIdle("restartFrame");
    @(posedge Fphi0);
    scanMode <= mode;
    width <= xCoordT'(w);
    height <= yCoordT'(h);
    pulseDlistEnd();
  endtask

  task automatic testColour();
    anCodeT codes[6];
    colorT  cols[6];
    anCodeT idle[3];
    logic   hb;
    logic   vb;
    codes = '{bgColor, playfield0, playfield1, playfield2, playfield3, lum1Col2};
    // lum1Col2 takes hue from PF2 and luminance from PF1
    cols = '{colbk, colpf0, colpf1, colpf2, colpf3, {colpf2[7:4], colpf1[3:0]}};
    idle = '{vSync, hBlankC40, noTransmission};
    restartFrame(lineScan, 16, 4);
    for (int i = 0; i < 6; i++)
      writePixel(codes[i], $sformatf("colour %s", codes[i].name()), bufAddrT'(i),
                 rgbFromColour(cols[i]), hb, vb);
    waitIdle("colour");
    foreach (idle[i]) begin
      @(posedge Fphi0);
      an <= idle[i];
      repeat (8) begin
        @(negedge Fphi0);
        if (anTake || dBufReq)
          failNow($sformatf("code %s was taken as a pixel", idle[i].name()));
      end
    end
    if (addrLog.size() != 0)
      failNow("a non-pixel code produced a display-buffer write");
    // The walker must not have moved on the idle codes
    writePixel(playfield0, "colour after idle", bufAddrT'(6), rgbFromColour(colpf0), hb, vb);
  endtask

  task automatic testLine();
    logic hb;
    logic vb;
    restartFrame(lineScan, 4, 2);
    for (int i = 0; i < 9; i++) begin
      writePixel(playfield1, "line", bufAddrT'(i % 8), rgbFromColour(colpf1), hb, vb);
      checkFlag($sformatf("line hblank %0d", i), i == 3, hb);
      checkFlag($sformatf("line vblank %0d", i), i == 7, vb);
    end
  endtask

  task automatic testBlock(input scanModeT mode, input int bw, input int w);
    logic hb;
    logic vb;
    int   n;
    restartFrame(mode, w, 8);
    n = 0;
    for (int bx = 0; bx < w / bw; bx++)
      for (int line = 0; line < 8; line++)
        for (int col = 0; col < bw; col++) begin
          n++;
          writePixel(playfield3, mode.name(), bufAddrT'(line * w + bx * bw + col),
                     rgbFromColour(colpf3), hb, vb);
          // One block row only, so the frame end is the only blank
          checkFlag($sformatf("%s hblank %0d", mode.name(), n), 1'b0, hb);
          checkFlag($sformatf("%s vblank %0d", mode.name(), n), n == w * 8, vb);
        end
  endtask

  task automatic testBackPressure();
    int takes;
    int waited;
    restartFrame(lineScan, 16, 8);
    takes = 0;
    waited = 0;
    @(posedge Fphi0);
    an <= playfield2;
    while (takes < 20) begin
      @(negedge Fphi0);
      waited++;
      if (waited > 20 * TimeoutCycles)
        failNow("timeout in backPressure waiting for 20 takes");
      if (anTake && (dBufReq || dBufAck))
        failNow("a code was taken while a display-buffer write was in progress");
      if (anTake)
        takes++;
    end
    @(posedge Fphi0);
    an <= noTransmission;
    waitIdle("backPressure");
    checkAddr("backPressure write count", bufAddrT'(takes), bufAddrT'(addrLog.size()));
    for (int i = 0; i < takes; i++)
      checkAddr("backPressure", bufAddrT'(i), addrLog.pop_front());
    dataLog.delete();
  endtask

  task automatic testDlist();
    logic hb;
    logic vb;
    restartFrame(lineScan, 8, 4);
    for (int i = 0; i < 5; i++)
      writePixel(bgColor, "dlist", bufAddrT'(i), rgbFromColour(colbk), hb, vb);
    waitIdle("dlist");
    pulseDlistEnd();
    writePixel(bgColor, "dlist restart", bufAddrT'(0), rgbFromColour(colbk), hb, vb);
  endtask

  initial begin
    void'($urandom(53910));
    Fphi0 = 1'b0;
    rst = 1'b1;
    an = noTransmission;
    colbk = 8'h08;
    colpf0 = 8'h3A;
    colpf1 = 8'h5F;
    colpf2 = 8'hC4;
    colpf3 = 8'h97;
    scanMode = lineScan;
    width = xCoordT'(4);
    height = yCoordT'(2);
    dlistEnd = 1'b0;
    repeat (3) @(posedge Fphi0);
    rst <= 1'b0;
    @(negedge Fphi0);
    checkFlag("reset dBufReq", 1'b0, dBufReq);
    checkFlag("reset anTake", 1'b0, anTake);
    checkFlag("reset hblank", 1'b0, hblank);
    checkFlag("reset vblank", 1'b0, vblank);
    testColour();
    testLine();
    testBlock(block8x8, 8, 16);
    testBlock(block16x8, 16, 32);
    testBackPressure();
    testDlist();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- bench/gtia_asserts.sv
// ################################################
// Handshake assertions bound into bufferWriter
// ################################################

module gtiaAsserts
  import gtiaPkg::*;
(
  input logic    Fphi0,
  input logic    rst,
  input logic    dBufReq,
  input logic    dBufAck,
  input bufAddrT dBufAddr,
  input rgbT     dBufData
);

  timeunit 1ns;
  timeprecision 100ps;

  // Request held until the buffer answers
  reqHeldUntilAck: assert property (@(posedge Fphi0) disable iff (rst)
    (dBufReq && !dBufAck) |=> dBufReq)
    else $error("dBufReq dropped before dBufAck was seen");

  // New request only after ack is gone
  noReqDuringAck: assert property (@(posedge Fphi0) disable iff (rst)
    (dBufAck && !dBufReq) |=> !dBufReq)
    else $error("dBufReq rose while dBufAck was still high");

  // Address and data held for the whole request phase
  dataHeldDuringReq: assert property (@(posedge Fphi0) disable iff (rst)
    dBufReq |=> ($stable(dBufAddr) && $stable(dBufData)))
    else $error("dBufAddr or dBufData changed while dBufReq was high");

endmodule

bind bufferWriter gtiaAsserts gtiaAsserts_inst (
  .Fphi0    (Fphi0),
  .rst      (rst),
  .dBufReq  (dBufReq),
  .dBufAck  (dBufAck),
  .dBufAddr (dBufAddr),
  .dBufData (dBufData)
);

//--- hw/bufferWriter.sv
// ################################################
// Pixel capture and four-phase display-buffer write
// ################################################

module bufferWriter
  import gtiaPkg::*;
(
  input  logic    Fphi0,
  input  logic    rst,
  input  logic    isPixel,
  input  rgbT     pixelRgb,
  input  xCoordT  pixelX,
  input  yCoordT  pixelY,
  input  xCoordT  width,
  output logic    anTake,
  output logic    dBufReq,
  input  logic    dBufAck,
  output bufAddrT dBufAddr,
  output rgbT     dBufData
);

  bufAddrT pixelAddr;

  // Idle only once the buffer has also dropped its ack
  assign anTake = isPixel && !dBufReq && !dBufAck;

  assign pixelAddr = bufAddrT'(pixelY) * bufAddrT'(width) + bufAddrT'(pixelX);

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      dBufReq <= 1'b0;
    end else begin
      if (anTake) begin
        dBufReq <= 1'b1;
      end else if (dBufReq && dBufAck) begin
        dBufReq <= 1'b0;
      end
    end
  end

  // Held stable for the whole request phase
  always_ff @(posedge Fphi0) begin
    if (anTake) begin
      dBufAddr <= pixelAddr;
      dBufData <= pixelRgb;
    end
  end

endmodule

//--- hw/colorSelect.sv
// ################################################
// ANTIC code decode and colour to RGB conversion
// ################################################

module colorSelect
  import gtiaPkg::*;
(
  input  anCodeT an,
  input  colorT  colbk,
  input  colorT  colpf0,
  input  colorT  colpf1,
  input  colorT  colpf2,
  input  colorT  colpf3,
  output rgbT    pixelRgb,
  output logic   isPixel
);

  colorT colour;
  logic [3:0] hue;
  logic [3:0] lum;
  rgbT baseRgb;

  // Channel scaled by (luminance+1)/16 and truncated
  function automatic logic [7:0] scaleChannel(input logic [7:0] level, input logic [3:0] luma);
    logic [4:0] factor;
    logic [11:0] product;
    factor = {1'b0, luma} + 5'd1;
    product = 12'(level) * 12'(factor);
    return product[11:4];
  endfunction

  always_comb begin
    colour = 8'h00;
    isPixel = 1'b0;
    case (an)
      bgColor: begin
        colour = colbk;
        isPixel = 1'b1;
      end
      lum1Col2: begin
        // Hue from PF2 and brightness from PF1
        colour = {colpf2[7:4], colpf1[3:0]};
        isPixel = 1'b1;
      end
      playfield0: begin
        colour = colpf0;
        isPixel = 1'b1;
      end
      playfield1: begin
        colour = colpf1;
        isPixel = 1'b1;
      end
      playfield2: begin
        colour = colpf2;
        isPixel = 1'b1;
      end
      playfield3: begin
        colour = colpf3;
        isPixel = 1'b1;
      end
      // vSync, hBlankC40 and idle carry no pixel
      default: begin
        colour = 8'h00;
        isPixel = 1'b0;
      end
    endcase
  end

  assign hue = colour[7:4];
  assign lum = colour[3:0];
  assign baseRgb = hueTable[hue];

  always_comb begin
    pixelRgb.r = scaleChannel(baseRgb.r, lum);
    pixelRgb.g = scaleChannel(baseRgb.g, lum);
    pixelRgb.b = scaleChannel(baseRgb.b, lum);
  end

endmodule

//--- hw/gtiaPkg.sv
// ################################################
// Shared types for the pixel path and the hue table
// ################################################

`include "gtia_config.svh"

package gtiaPkg;

  // Upper nibble is hue, lower nibble is luminance
  typedef logic [7:0] colorT;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgbT;

  typedef logic [`GTIA_X_W-1:0] xCoordT;
  typedef logic [`GTIA_Y_W-1:0] yCoordT;
  typedef logic [`GTIA_ADDR_W-1:0] bufAddrT;

  // Playfield codes from ANTIC in normal mode
  typedef enum logic [3:0] {
    bgColor        = 4'd0,
    vSync          = 4'd1,
    hBlankC40      = 4'd2,
    lum1Col2       = 4'd3,
    playfield0     = 4'd4,
    playfield1     = 4'd5,
    playfield2     = 4'd6,
    playfield3     = 4'd7,
    noTransmission = 4'd15
  } anCodeT;

  typedef enum logic [1:0] {
    lineScan  = 2'd0,
    block8x8  = 2'd1,
    block16x8 = 2'd2
  } scanModeT;

  // Full-brightness base colour per hue, hue 0 is the grey ramp
  localparam rgbT hueTable [16] = '{
    24'hFFFFFF, 24'hFFD040, 24'hFF9020, 24'hFF6040,
    24'hFF4080, 24'hE040E0, 24'hA040FF, 24'h6060FF,
    24'h4090FF, 24'h40C0FF, 24'h40E0E0, 24'h40FFA0,
    24'h40FF40, 24'hA0FF40, 24'hE0E040, 24'hFFB040
  };

endpackage

//--- hw/gtiaTop.sv
// ################################################
// Pixel path top level
// ################################################

module gtiaTop
  import gtiaPkg::*;
(
  input  logic     Fphi0,
  input  logic     rst,
  input  anCodeT   an,
  input  colorT    colbk,
  input  colorT    colpf0,
  input  colorT    colpf1,
  input  colorT    colpf2,
  input  colorT    colpf3,
  input  scanModeT scanMode,
  input  xCoordT   width,
  input  yCoordT   height,
  input  logic     dlistEnd,
  input  logic     dBufAck,
  output logic     anTake,
  output logic     dBufReq,
  output bufAddrT  dBufAddr,
  output rgbT      dBufData,
  output logic     hblank,
  output logic     vblank
);

  rgbT    pixelRgb;
  logic   isPixel;
  xCoordT pixelX;
  yCoordT pixelY;

  colorSelect colorSelect_inst (
    .an       (an),
    .colbk    (colbk),
    .colpf0   (colpf0),
    .colpf1   (colpf1),
    .colpf2   (colpf2),
    .colpf3   (colpf3),
    .pixelRgb (pixelRgb),
    .isPixel  (isPixel)
  );

  // Walker advances on every consumed pixel
  scanWalker scanWalker_inst (
    .Fphi0    (Fphi0),
    .rst      (rst),
    .step     (anTake),
    .dlistEnd (dlistEnd),
    .scanMode (scanMode),
    .width    (width),
    .height   (height),
    .pixelX   (pixelX),
    .pixelY   (pixelY),
    .hblank   (hblank),
    .vblank   (vblank)
  );

  bufferWriter bufferWriter_inst (
    .Fphi0    (Fphi0),
    .rst      (rst),
    .isPixel  (isPixel),
    .pixelRgb (pixelRgb),
    .pixelX   (pixelX),
    .pixelY   (pixelY),
    .width    (width),
    .anTake   (anTake),
    .dBufReq  (dBufReq),
    .dBufAck  (dBufAck),
    .dBufAddr (dBufAddr),
    .dBufData (dBufData)
  );

endmodule

//--- hw/scanWalker.sv
// ################################################
// Screen coordinate walker, line and block orders
// ################################################

module scanWalker
  import gtiaPkg::*;
(
  input  logic     Fphi0,
  input  logic     rst,
  input  logic     step,
  input  logic     dlistEnd,
  input  scanModeT scanMode,
  input  xCoordT   width,
  input  yCoordT   height,
  output xCoordT   pixelX,
  output yCoordT   pixelY,
  output logic     hblank,
  output logic     vblank
);

  logic   lastX;
  logic   lastY;
  logic   xBlkEnd;
  logic   yBlkEnd;
  xCoordT blkSpan;
  xCoordT nextX;
  yCoordT nextY;
  logic   nextH;
  logic   nextV;

  assign lastX = (pixelX == width - xCoordT'(1));
  assign lastY = (pixelY == height - yCoordT'(1));

  // Offset of the last pixel inside a block
  assign blkSpan = (scanMode == block16x8) ? xCoordT'(15) : xCoordT'(7);
  assign xBlkEnd = ((pixelX & blkSpan) == blkSpan);
  // Block rows are 8 lines and start on multiples of 8
  assign yBlkEnd = (pixelY[2:0] == 3'd7);

  always_comb begin
    nextX = pixelX + xCoordT'(1);
    nextY = pixelY;
    nextH = 1'b0;
    nextV = 1'b0;
    if (lastX && lastY) begin
      // End of frame, back to the origin
      nextX = '0;
      nextY = '0;
      nextV = 1'b1;
    end else if (scanMode == block8x8 || scanMode == block16x8) begin
      if (lastX && yBlkEnd) begin
        nextX = '0;
        nextY = pixelY + yCoordT'(1);
        nextH = 1'b1;
      end else if (xBlkEnd && yBlkEnd) begin
        // Next block to the right, top line of the row
        nextY = pixelY - yCoordT'(7);
      end else if (xBlkEnd) begin
        nextX = pixelX - blkSpan;
        nextY = pixelY + yCoordT'(1);
      end
    end else if (lastX) begin
      nextX = '0;
      nextY = pixelY + yCoordT'(1);
      nextH = 1'b1;
    end
  end

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      pixelX <= '0;
      pixelY <= '0;
      hblank <= 1'b0;
      vblank <= 1'b0;
    end else begin
      hblank <= 1'b0;
      vblank <= 1'b0;
      if (dlistEnd) begin
        pixelX <= '0;
        pixelY <= '0;
      end else if (step) begin
        pixelX <= nextX;
        pixelY <= nextY;
        hblank <= nextH;
        vblank <= nextV;
      end
    end
  end

endmodule

//--- include/gtia_config.svh
// ################################################
// Screen geometry and display-buffer address sizes
// ################################################

`ifndef GTIA_CONFIG_SVH
`define GTIA_CONFIG_SVH

// Horizontal coordinate, enough for 320 pixels
`define GTIA_X_W 9

// Vertical coordinate
`define GTIA_Y_W 8

// Display-buffer word address, holds y*width+x for the largest screen
`define GTIA_ADDR_W 17

// Widest screen the address range was sized for
`define GTIA_MAX_WIDTH 320

`endif

//--- run.sh
#!/bin/sh
# Build and run the pixel-path simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f sources.f --top-module gtiaTb -o gtiaSim

./obj_dir/gtiaSim | tee sim.log

grep -q "Simulation finished: PASS" sim.log

//--- sources.f
+incdir+include
hw/gtiaPkg.sv
hw/colorSelect.sv
hw/scanWalker.sv
hw/bufferWriter.sv
hw/gtiaTop.sv
bench/gtia_asserts.sv
bench/gtiaTb.sv
